// ==== tb.f ====
+incdir+test
hw/plru_pkg.sv
hw/plru_tree_store.sv
hw/plru_port_arbiter.sv
hw/plru_hit_update.sv
hw/plru_victim_select.sv
hw/plru_top.sv
test/tb_plru_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PLRU replacement unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_plru_top -Mdir "$OBJ_DIR" -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_plru_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== test/plru_ref_model.svh ====
/*
 * Reference model of the PLRU trees
 * Keeps one tree word per set and applies the hit and victim rules
 */
`ifndef PLRU_REF_MODEL_SVH
`define PLRU_REF_MODEL_SVH

tree_word_t ref_tree [PLRU_SETS];

function automatic void ref_reset();
    ref_tree = '{default: '0};
endfunction

// True when ways first to first+count-1 are all set in vec
function automatic bit all_ways(way_vec_t vec, int first, int count);
    way_vec_t mask;
    mask = way_vec_t'(((65'd1 << count) - 65'd1) << first);
    return (vec & mask) == mask;
endfunction

function automatic tree_word_t with_node(tree_word_t t, int node, bit val);
    tree_word_t m;
    m = tree_word_t'(1) << node;
    return val ? (t | m) : (t & ~m);
endfunction

// Point every node on the path at the hit way
function automatic void ref_hit(set_idx_t set, way_vec_t way);
    tree_word_t t;
    int         w;
    int         lo;
    int         size;
    int         node;
    w = 0;
    for (int i = 0; i < PLRU_WAYS; i++) begin
        if (1'(way >> i)) begin
            w = i;
        end
    end
    t    = ref_tree[set];
    lo   = 0;
    size = PLRU_WAYS;
    node = 0;
    while (size > 1) begin
        size = size / 2;
        // Upper half used last clears the node, lower half sets it
        if (w >= lo + size) begin
            t    = with_node(t, node, 1'b0);
            lo   = lo + size;
            node = 2 * node + 2;
        end else begin
            t    = with_node(t, node, 1'b1);
            node = 2 * node + 1;
        end
    end
    ref_tree[set] = t;
endfunction

// Walk to the victim, mark the path as used and return the one-hot way
function automatic way_vec_t ref_evict(set_idx_t set, way_state_t state);
    tree_word_t t;
    way_vec_t   occ;
    int         lo;
    int         size;
    int         node;
    bit         full;
    bit         lo_blk;
    bit         hi_blk;
    bit         go_up;
    occ  = state.valid | state.lock;
    t    = ref_tree[set];
    lo   = 0;
    size = PLRU_WAYS;
    node = 0;
    while (size > 1) begin
        full = all_ways(occ, lo, size);
        size = size / 2;
        // A full subtree is only blocked by locks
        if (full) begin
            lo_blk = all_ways(state.lock, lo, size);
            hi_blk = all_ways(state.lock, lo + size, size);
        end else begin
            lo_blk = all_ways(occ, lo, size);
            hi_blk = all_ways(occ, lo + size, size);
        end
        if (hi_blk != lo_blk) begin
            go_up = lo_blk;
        end else begin
            // Away from the half used last
            go_up = 1'(t >> node);
        end
        t    = with_node(t, node, !go_up);
        lo   = go_up ? lo + size : lo;
        node = go_up ? 2 * node + 2 : 2 * node + 1;
    end
    ref_tree[set] = t;
    return way_vec_t'(1) << lo;
endfunction

`endif

// ==== test/tb_plru_top.sv ====
/*
 * Testbench for the PLRU replacement unit
 * Directed tests drive hits and evictions and compare the victims and
 * dirty flags with a reference tree model
 */
`default_nettype none

module tb_plru_top;
    timeunit 1ns;
    timeprecision 100ps;

    import plru_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int DONE_LIMIT      = 16;
    localparam int HIT_ROUNDS      = 18;
    localparam int LOCK_ROUNDS     = 24;
    localparam int DIRTY_ROUNDS    = 10;
    localparam int CONTEND_ROUNDS  = 4;
    // Hit rounds and contention rounds carry two requests each
    localparam int NUM_REQUESTS    = PLRU_WAYS + 2 * HIT_ROUNDS + LOCK_ROUNDS
                                     + DIRTY_ROUNDS + 2 * CONTEND_ROUNDS;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 20 + RESET_CYCLES;

    logic       clk;
    logic       reset;
    logic       hit;
    set_idx_t   hit_set;
    way_vec_t   hit_way;
    logic       evict;
    set_idx_t   evict_set;
    way_state_t way_state;
    logic       hit_done;
    logic       evict_done;
    way_vec_t   victim_way;
    logic       victim_dirty;

    integer seed   = 32'he122;
    int     errors = 0;
    int     checks = 0;

    `include "plru_ref_model.svh"

    plru_top plru_top_i (
        .clk_i          (clk),
        .reset_i        (reset),
        .hit_i          (hit),
        .hit_set_i      (hit_set),
        .hit_way_i      (hit_way),
        .evict_i        (evict),
        .evict_set_i    (evict_set),
        .way_state_i    (way_state),
        .hit_done_o     (hit_done),
        .evict_done_o   (evict_done),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    function automatic way_vec_t rand_ways();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[PLRU_WAYS-1:0];
    endfunction

    function automatic way_vec_t rand_way();
        return way_vec_t'(1) << ({$random(seed)} % PLRU_WAYS);
    endfunction

    // Never all ways locked, so there is always a victim
    function automatic way_vec_t rand_lock();
        way_vec_t v;
        v = rand_ways();
        if (&v) begin
            v[0] = 1'b0;
        end
        return v;
    endfunction

    function automatic set_idx_t rand_set();
        return set_idx_t'({$random(seed)} % PLRU_SETS);
    endfunction

    function automatic way_state_t make_state(way_vec_t valid, way_vec_t lock, way_vec_t dirty);
        way_state_t s;
        s.valid = valid;
        s.lock  = lock;
        s.dirty = dirty;
        return s;
    endfunction

    task automatic check_way(string name, way_vec_t expected, way_vec_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic report_rule(string what);
        errors++;
        $display("Rule broken at %0t ns: %s", $time, what);
    endtask

    // Raise the chosen levels together and hold each one until its done
    task automatic run_request(input bit with_hit, input bit with_evict, input set_idx_t set,
                               input way_vec_t way, input way_state_t state,
                               output int hit_cycle, output int evict_cycle,
                               output way_vec_t got_way, output logic got_dirty);
        int cycles;
        bit hit_seen;
        bit evict_seen;
        hit_cycle   = 0;
        evict_cycle = 0;
        got_way     = '0;
        got_dirty   = 1'b0;
        hit_seen    = !with_hit;
        evict_seen  = !with_evict;
        cycles      = 0;
        @(posedge clk);
        #1;
        hit       = with_hit;
        hit_set   = set;
        hit_way   = way;
        evict     = with_evict;
        evict_set = set;
        way_state = state;
        while (!(hit_seen && evict_seen) && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (hit && hit_done) begin
                hit_seen  = 1'b1;
                hit_cycle = cycles;
            end
            if (evict && evict_done) begin
                evict_seen  = 1'b1;
                evict_cycle = cycles;
                got_way     = victim_way;
                got_dirty   = victim_dirty;
            end
            // Level drops in the cycle after its done
            @(posedge clk);
            #1;
            hit   = hit && !hit_seen;
            evict = evict && !evict_seen;
        end
        if (!hit_seen) begin
            report_rule($sformatf("hit on set %0d got no done in %0d cycles", set, DONE_LIMIT));
        end
        if (!evict_seen) begin
            report_rule($sformatf("eviction on set %0d got no done in %0d cycles",
                                  set, DONE_LIMIT));
        end
        hit   = 1'b0;
        evict = 1'b0;
    endtask

    task automatic test_fresh_sets();
        way_state_t state;
        way_vec_t   got;
        way_vec_t   visited;
        logic       dirty;
        int         hc;
        int         ec;
        set_idx_t   set;
        set     = rand_set();
        state   = make_state('1, '0, '0);
        visited = '0;
        for (int i = 0; i < PLRU_WAYS; i++) begin
            run_request(1'b0, 1'b1, set, '0, state, hc, ec, got, dirty);
            check_way("victim_way_o", ref_evict(set, state), got);
            check_bit("victim_dirty_o", 1'b0, dirty);
            if ((visited & got) != '0) begin
                report_rule($sformatf("way %h chosen twice on a fresh set", got));
            end
            visited = visited | got;
        end
        if (visited != '1) begin
            report_rule($sformatf("fresh set evictions only visited ways %h", visited));
        end
    endtask

    task automatic test_hit_updates();
        way_state_t state;
        way_vec_t   way;
        way_vec_t   got;
        logic       dirty;
        int         hc;
        int         ec;
        set_idx_t   set;
        state = make_state('1, '0, '0);
        for (int i = 0; i < HIT_ROUNDS; i++) begin
            set = rand_set();
            way = rand_way();
            run_request(1'b1, 1'b0, set, way, state, hc, ec, got, dirty);
            ref_hit(set, way);
            run_request(1'b0, 1'b1, set, way, state, hc, ec, got, dirty);
            check_way("victim_way_o", ref_evict(set, state), got);
            if (got == way) begin
                report_rule($sformatf("victim %h on set %0d is the way just hit", got, set));
            end
        end
    endtask

    // Even rounds keep every way valid, odd rounds leave some free
    task automatic test_lock_and_free();
        way_state_t state;
        way_vec_t   valid;
        way_vec_t   lock;
        way_vec_t   free;
        way_vec_t   got;
        logic       dirty;
        int         hc;
        int         ec;
        set_idx_t   set;
        for (int i = 0; i < LOCK_ROUNDS; i++) begin
            set  = rand_set();
            lock = rand_lock();
            if (i % 2 == 0) begin
                valid = '1;
            end else begin
                valid = rand_ways();
            end
            state = make_state(valid, lock, '0);
            free  = ~valid & ~lock;
            run_request(1'b0, 1'b1, set, '0, state, hc, ec, got, dirty);
            check_way("victim_way_o", ref_evict(set, state), got);
            if ((got & lock) != '0) begin
                report_rule($sformatf("locked way %h chosen, lock vector %h", got, lock));
            end
            if (free != '0 && (got & free) == '0) begin
                report_rule($sformatf("way %h chosen although free ways %h exist", got, free));
            end
        end
    endtask

    task automatic test_dirty_flag();
        way_state_t state;
        way_vec_t   expected;
        way_vec_t   got;
        logic       dirty;
        int         hc;
        int         ec;
        set_idx_t   set;
        for (int i = 0; i < DIRTY_ROUNDS; i++) begin
            set   = rand_set();
            state = make_state('1, rand_lock(), rand_ways());
            run_request(1'b0, 1'b1, set, '0, state, hc, ec, got, dirty);
            expected = ref_evict(set, state);
            check_way("victim_way_o", expected, got);
            check_bit("victim_dirty_o", |(expected & state.dirty), dirty);
        end
    endtask

    // Hit and eviction raised together, the hit owns the store first
    task automatic test_contention();
        way_state_t state;
        way_vec_t   way;
        way_vec_t   expected;
        way_vec_t   got;
        logic       dirty;
        int         hc;
        int         ec;
        set_idx_t   set;
        tree_word_t saved;
        for (int i = 0; i < CONTEND_ROUNDS; i++) begin
            set   = rand_set();
            state = make_state('1, '0, rand_ways());
            // Hit the way the model would evict next, so the hit moves the victim
            saved         = ref_tree[set];
            way           = ref_evict(set, state);
            ref_tree[set] = saved;
            run_request(1'b1, 1'b1, set, way, state, hc, ec, got, dirty);
            ref_hit(set, way);
            expected = ref_evict(set, state);
            check_way("victim_way_o", expected, got);
            check_bit("victim_dirty_o", |(expected & state.dirty), dirty);
            if (hc == 0 || ec != hc + 2) begin
                report_rule($sformatf("hit done at cycle %0d, eviction done at cycle %0d",
                                      hc, ec));
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        hit       = 1'b0;
        hit_set   = '0;
        hit_way   = '0;
        evict     = 1'b0;
        evict_set = '0;
        way_state = '0;
        ref_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        test_fresh_sets();
        test_hit_updates();
        test_lock_and_free();
        test_dirty_flag();
        test_contention();
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/plru_top.sv ====
/*
 * PLRU replacement unit top level
 * Hit updater and victim selector share one tree store through the port
 * arbiter
 */
`default_nettype none

module plru_top (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 hit_i,
    input  wire plru_pkg::set_idx_t   hit_set_i,
    input  wire plru_pkg::way_vec_t   hit_way_i,
    input  wire logic                 evict_i,
    input  wire plru_pkg::set_idx_t   evict_set_i,
    input  wire plru_pkg::way_state_t way_state_i,
    output logic                      hit_done_o,
    output logic                      evict_done_o,
    output plru_pkg::way_vec_t        victim_way_o,
    output logic                      victim_dirty_o
);
    import plru_pkg::*;

    store_req_t hit_req;
    store_req_t evict_req;
    store_req_t store_req;
    logic [1:0] grant;
    tree_word_t rdata;

    // Unsupported associativity stops elaboration
    if (!PLRU_WAYS_OK) begin : g_ways_check
        $fatal(1, "PLRU_WAYS must be a power of two from 2 to 64");
    end

    plru_hit_update plru_hit_update_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .hit_i       (hit_i),
        .hit_set_i   (hit_set_i),
        .hit_way_i   (hit_way_i),
        .grant_i     (grant[0]),
        .rdata_i     (rdata),
        .store_req_o (hit_req),
        .hit_done_o  (hit_done_o)
    );

    plru_victim_select plru_victim_select_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .evict_i        (evict_i),
        .evict_set_i    (evict_set_i),
        .way_state_i    (way_state_i),
        .grant_i        (grant[1]),
        .rdata_i        (rdata),
        .store_req_o    (evict_req),
        .evict_done_o   (evict_done_o),
        .victim_way_o   (victim_way_o),
        .victim_dirty_o (victim_dirty_o)
    );

    plru_port_arbiter plru_port_arbiter_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .hit_req_i   (hit_req),
        .evict_req_i (evict_req),
        .grant_o     (grant),
        .store_req_o (store_req)
    );

    plru_tree_store plru_tree_store_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (store_req),
        .rdata_o (rdata)
    );

endmodule

`default_nettype wire

// ==== hw/plru_victim_select.sv ====
/*
 * PLRU victim selector
 * On an eviction request, walks the set's tree from the root to a victim
 * way. Locked ways are never taken and free ways are preferred. The walked
 * path is written back as most recently used.
 */
`default_nettype none

module plru_victim_select (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 evict_i,
    input  wire plru_pkg::set_idx_t   evict_set_i,
    input  wire plru_pkg::way_state_t way_state_i,
    input  wire logic                 grant_i,
    input  wire plru_pkg::tree_word_t rdata_i,
    output plru_pkg::store_req_t      store_req_o,
    output logic                      evict_done_o,
    output plru_pkg::way_vec_t        victim_way_o,
    output logic                      victim_dirty_o
);
    import plru_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_holdoff
    } state_e;

    state_e     state_q;
    state_e     state_d;
    way_vec_t   occupied;
    way_vec_t   walk_victim;
    logic       walk_dirty;
    tree_word_t new_word;
    way_vec_t   victim_q;
    logic       dirty_q;

    assign occupied = way_state_i.valid | way_state_i.lock;

    always_comb begin : victim_walk
        int       node;
        int       base;
        int       half;
        logic     dir;
        logic     sub_full;
        logic     lo_blk;
        logic     hi_blk;
        way_vec_t lo_mask;
        way_vec_t hi_mask;
        new_word    = rdata_i;
        walk_victim = '0;
        node        = 0;
        base        = 0;
        for (int lvl = 0; lvl < TREE_LEVELS; lvl++) begin
            half    = PLRU_WAYS >> (lvl + 1);
            lo_mask = '0;
            hi_mask = '0;
            for (int w = 0; w < PLRU_WAYS; w++) begin
                lo_mask[w] = (w >= base) && (w < base + half);
                hi_mask[w] = (w >= base + half) && (w < base + 2 * half);
            end
            sub_full = ((occupied & (lo_mask | hi_mask)) == (lo_mask | hi_mask));
            // Full subtree, only locks block a half
            if (sub_full) begin
                lo_blk = ((way_state_i.lock & lo_mask) == lo_mask);
                hi_blk = ((way_state_i.lock & hi_mask) == hi_mask);
            end else begin
                lo_blk = ((occupied & lo_mask) == lo_mask);
                hi_blk = ((occupied & hi_mask) == hi_mask);
            end
            // dir 1 takes the upper half
            if (hi_blk && !lo_blk) begin
                dir = 1'b0;
            end else if (lo_blk && !hi_blk) begin
                dir = 1'b1;
            end else begin
                dir = new_word[node];
            end
            new_word[node] = ~dir;
            base           = base + (dir ? half : 0);
            node           = 2 * node + 1 + int'(dir);
        end
        walk_victim[base] = 1'b1;
    end

    assign walk_dirty = |(walk_victim & way_state_i.dirty);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (evict_i && grant_i) begin
                    state_d = st_read;
                end
            end
            st_read:    state_d = st_holdoff;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= st_idle;
            victim_q <= '0;
            dirty_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (evict_done_o) begin
                victim_q <= walk_victim;
                dirty_q  <= walk_dirty;
            end
        end
    end

    always_comb begin
        store_req_o.strobe  = ((state_q == st_idle) && evict_i) || (state_q == st_read);
        store_req_o.we      = (state_q == st_read);
        store_req_o.set_idx = evict_set_i;
        store_req_o.wdata   = new_word;
    end

    assign evict_done_o = (state_q == st_read);

    // Fresh result with done, held afterwards until the next eviction
    assign victim_way_o   = evict_done_o ? walk_victim : victim_q;
    assign victim_dirty_o = evict_done_o ? walk_dirty : dirty_q;

    // A locked way is never evicted while some way is unlocked
    a_victim_unlocked: assert property (@(posedge clk_i) disable iff (reset_i)
        (evict_done_o && !(&way_state_i.lock)) |-> ((victim_way_o & way_state_i.lock) == '0));

endmodule

`default_nettype wire

// ==== hw/plru_hit_update.sv ====
/*
 * PLRU hit updater
 * On a hit, reads the set's tree word, turns every node on the path to the
 * hit way towards that way and writes the word back
 */
`default_nettype none

module plru_hit_update (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 hit_i,
    input  wire plru_pkg::set_idx_t   hit_set_i,
    input  wire plru_pkg::way_vec_t   hit_way_i,
    input  wire logic                 grant_i,
    input  wire plru_pkg::tree_word_t rdata_i,
    output plru_pkg::store_req_t      store_req_o,
    output logic                      hit_done_o
);
    import plru_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_holdoff
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    logic [TREE_LEVELS-1:0] way_idx;
    tree_word_t             new_word;

    // Binary index of the one-hot hit way
    always_comb begin
        way_idx = '0;
        for (int w = 0; w < PLRU_WAYS; w++) begin
            if (hit_way_i[w]) begin
                way_idx = way_idx | TREE_LEVELS'(w);
            end
        end
    end

    // Walk from the root, index bits MSB first pick the child
    always_comb begin : path_update
        int   node;
        logic upper;
        new_word = rdata_i;
        node     = 0;
        for (int lvl = 0; lvl < TREE_LEVELS; lvl++) begin
            upper          = way_idx[TREE_LEVELS-1-lvl];
            // 0 marks the upper half as last used, 1 the lower half
            new_word[node] = ~upper;
            node           = 2 * node + 1 + int'(upper);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (hit_i && grant_i) begin
                    state_d = st_read;
                end
            end
            st_read:    state_d = st_holdoff;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Read while waiting for the grant, write back once the word is in
    always_comb begin
        store_req_o.strobe  = ((state_q == st_idle) && hit_i) || (state_q == st_read);
        store_req_o.we      = (state_q == st_read);
        store_req_o.set_idx = hit_set_i;
        store_req_o.wdata   = new_word;
    end

    assign hit_done_o = (state_q == st_read);

    a_hit_way_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        hit_i |-> $onehot(hit_way_i));

    // Write-back must still own the store port
    a_write_granted: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == st_read) |-> grant_i);

endmodule

`default_nettype wire

// ==== hw/plru_port_arbiter.sv ====
/*
 * PLRU store port arbiter
 * Hands the single tree store port to the hit engine or the victim engine
 * for a two-cycle read-modify-write. Hit requests win over evictions.
 */
`default_nettype none

module plru_port_arbiter (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire plru_pkg::store_req_t hit_req_i,
    input  wire plru_pkg::store_req_t evict_req_i,
    output logic [1:0]                grant_o,
    output plru_pkg::store_req_t      store_req_o
);
    // Bit 0 is the hit engine, bit 1 the victim engine
    logic [1:0] grant_q;
    logic [1:0] busy_cnt_q;
    logic       hit_start;
    logic       evict_start;
    logic       can_grant;

    // Every access opens with a read, the write-back is never a new request
    assign hit_start   = hit_req_i.strobe && !hit_req_i.we;
    assign evict_start = evict_req_i.strobe && !evict_req_i.we;

    // Free next cycle when idle or in the last cycle of an access
    assign can_grant = (busy_cnt_q <= 2'd1);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            grant_q    <= '0;
            busy_cnt_q <= '0;
        end else if (can_grant) begin
            if (hit_start) begin
                grant_q    <= 2'b01;
                busy_cnt_q <= 2'd2;
            end else if (evict_start) begin
                grant_q    <= 2'b10;
                busy_cnt_q <= 2'd2;
            end else begin
                grant_q    <= '0;
                busy_cnt_q <= '0;
            end
        end else begin
            busy_cnt_q <= busy_cnt_q - 2'd1;
        end
    end

    // Owner's request goes through to the store
    always_comb begin
        store_req_o = '0;
        if (grant_q[0]) begin
            store_req_o = hit_req_i;
        end else if (grant_q[1]) begin
            store_req_o = evict_req_i;
        end
    end

    assign grant_o = grant_q;

    // Second cycle of a grant is the owner's write-back to the set it read
    a_write_back_same_set: assert property (@(posedge clk_i) disable iff (reset_i)
        (busy_cnt_q == 2'd1) |-> (store_req_o.strobe && store_req_o.we
            && (store_req_o.set_idx == $past(store_req_o.set_idx))));

    // Each grant covers the read and the write-back, nothing more
    for (genvar g = 0; g < 2; g++) begin : g_grant_len
        a_grant_two_cycles: assert property (@(posedge clk_i) disable iff (reset_i)
            $rose(grant_q[g]) |=> grant_q[g] ##1 !grant_q[g]);
    end

endmodule

`default_nettype wire

// ==== hw/plru_tree_store.sv ====
/*
 * PLRU tree store
 * One tree word per cache set in a register array. Single port, read data
 * is registered and shows one cycle after the read request. The whole
 * array clears to zero on reset.
 */
`default_nettype none

module plru_tree_store (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire plru_pkg::store_req_t req_i,
    output plru_pkg::tree_word_t      rdata_o
);
    import plru_pkg::*;

    tree_word_t mem_q [PLRU_SETS];
    tree_word_t rdata_q;
    logic       wr_en;
    logic       rd_en;

    assign wr_en = req_i.strobe && req_i.we;
    assign rd_en = req_i.strobe && !req_i.we;

    // Tree words, all nodes back to zero on reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < PLRU_SETS; s++) begin
                mem_q[s] <= '0;
            end
        end else if (wr_en) begin
            mem_q[req_i.set_idx] <= req_i.wdata;
        end
    end

    // Read port register
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= mem_q[req_i.set_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== hw/plru_pkg.sv ====
/*
 * PLRU replacement unit package
 * Cache geometry, derived widths and the struct types shared by the
 * store, the arbiter and both engines
 */
`default_nettype none

package plru_pkg;

    // Cache geometry
    localparam int unsigned PLRU_WAYS = 8;
    localparam int unsigned PLRU_SETS = 16;

    // Ways must be a power of two from 2 to 64
    localparam bit PLRU_WAYS_OK = (PLRU_WAYS >= 2) && (PLRU_WAYS <= 64)
        && ((PLRU_WAYS & (PLRU_WAYS - 1)) == 0);

    // Heap-ordered tree, one bit per inner node
    localparam int unsigned TREE_BITS    = PLRU_WAYS - 1;
    localparam int unsigned TREE_LEVELS  = $clog2(PLRU_WAYS);
    localparam int unsigned SET_IDX_BITS = (PLRU_SETS > 1) ? $clog2(PLRU_SETS) : 1;

    typedef logic [PLRU_WAYS-1:0]    way_vec_t;
    typedef logic [TREE_BITS-1:0]    tree_word_t;
    typedef logic [SET_IDX_BITS-1:0] set_idx_t;

    // One access to the tree store
    typedef struct packed {
        logic       strobe;
        logic       we;
        set_idx_t   set_idx;
        tree_word_t wdata;
    } store_req_t;

    // Tag state of one set as seen by the victim selector
    typedef struct packed {
        way_vec_t valid;
        way_vec_t lock;
        way_vec_t dirty;
    } way_state_t;

endpackage

`default_nettype wire
